// File: files.f
logic/rv_pkg.sv
logic/control_unit.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/rv_core.sv
verification/rv_core_asserts.sv
verification/rv_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the core testbench with Verilator, run it, and grade by the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert --top-module rv_core_tb -f files.f -o rv_core_sim \
    && ./obj_dir/rv_core_sim 2>&1 | tee "$LOG" \
    || echo "Build or simulation error"

grep -qx "Test OK" "$LOG" 2>/dev/null \
    && echo "Simulation passed" \
    && exit 0 \
    || { echo "Simulation failed"; exit 1; }

// File: verification/rv_core_tb.sv
`timescale 1ns/10ps

module rv_core_tb;

    localparam int PERIOD       = 8;
    localparam int RESET_CYCLES = 2;
    localparam int N_ROWS       = 31;
    // Worst case three cycles a row, plus reset and startup slack
    localparam int TIMEOUT_NS   = (N_ROWS * 3 + RESET_CYCLES + 4) * PERIOD;

    // RV32 opcode and funct encodings
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BAD    = 7'b1111111;
    localparam logic [2:0] F3_ADD     = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_WORD    = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRA     = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;

    logic        clk_i;
    logic        arst_n_i;
    logic [31:0] instr_i;
    logic        instr_valid_i;
    logic [31:0] pc_o;
    logic        wb_valid_o;
    logic [4:0]  wb_rd_o;
    logic [31:0] wb_data_o;

    // Program table, one row per word address
    logic [31:0] prog_instr [N_ROWS];
    string       prog_name  [N_ROWS];
    logic        exp_valid  [N_ROWS];
    logic [4:0]  exp_rd     [N_ROWS];
    logic [31:0] exp_data   [N_ROWS];
    logic [31:0] exp_pc     [N_ROWS];
    int          row_count;

    int row_errors;
    int pass_count;
    int fail_count;

    rv_core rv_core_i (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .pc_o          (pc_o),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #(PERIOD / 2) clk_i = ~clk_i;
    end

    // Instruction assemblers
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OPC_STORE};
    endfunction

    // beq only, funct3 000
    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    task automatic put_row(input logic [31:0] word, input string name, input logic valid,
                           input logic [4:0] rd, input logic [31:0] data,
                           input logic [31:0] next_pc);
        prog_instr[row_count] = word;
        prog_name[row_count]  = name;
        exp_valid[row_count]  = valid;
        exp_rd[row_count]     = rd;
        exp_data[row_count]   = data;
        exp_pc[row_count]     = next_pc;
        row_count++;
    endtask

    // x1 = 12 and x2 = -7 feed the arithmetic rows
    task automatic load_program();
        put_row(enc_i(12'd12, 5'd0, F3_ADD, 5'd1, OPC_IMM), "addi_pos", 1'b1, 5'd1, 32'hC, 32'h04);
        put_row(enc_i(12'hFF9, 5'd0, F3_ADD, 5'd2, OPC_IMM), "addi_neg", 1'b1, 5'd2,
                32'hFFFF_FFF9, 32'h08);
        put_row(enc_r(F7_BASE, 5'd2, 5'd1, F3_ADD, 5'd3), "add", 1'b1, 5'd3, 32'h5, 32'h0C);
        put_row(enc_r(F7_ALT, 5'd2, 5'd1, F3_ADD, 5'd4), "sub", 1'b1, 5'd4, 32'h13, 32'h10);
        put_row(enc_r(F7_BASE, 5'd2, 5'd1, F3_AND, 5'd5), "and", 1'b1, 5'd5, 32'h8, 32'h14);
        put_row(enc_r(F7_BASE, 5'd2, 5'd1, F3_OR, 5'd6), "or", 1'b1, 5'd6, 32'hFFFF_FFFD, 32'h18);
        put_row(enc_r(F7_BASE, 5'd2, 5'd1, F3_XOR, 5'd7), "xor", 1'b1, 5'd7, 32'hFFFF_FFF5, 32'h1C);
        put_row(enc_r(F7_BASE, 5'd3, 5'd1, F3_SLL, 5'd8), "sll", 1'b1, 5'd8, 32'h180, 32'h20);
        put_row(enc_r(F7_BASE, 5'd1, 5'd2, F3_SLT, 5'd9), "slt_true", 1'b1, 5'd9, 32'h1, 32'h24);
        put_row(enc_r(F7_BASE, 5'd2, 5'd1, F3_SLT, 5'd10), "slt_false", 1'b1, 5'd10, 32'h0, 32'h28);
        put_row(enc_i(12'h0F0, 5'd2, F3_AND, 5'd11, OPC_IMM), "andi", 1'b1, 5'd11, 32'hF0, 32'h2C);
        put_row(enc_i(12'h301, 5'd1, F3_OR, 5'd12, OPC_IMM), "ori", 1'b1, 5'd12, 32'h30D, 32'h30);
        put_row(enc_i(12'hFFF, 5'd1, F3_XOR, 5'd13, OPC_IMM), "xori", 1'b1, 5'd13,
                32'hFFFF_FFF3, 32'h34);
        put_row(enc_i(12'hFFA, 5'd2, F3_SLT, 5'd14, OPC_IMM), "slti", 1'b1, 5'd14, 32'h1, 32'h38);
        put_row(enc_i(12'h004, 5'd1, F3_SLL, 5'd15, OPC_IMM), "slli", 1'b1, 5'd15, 32'hC0, 32'h3C);
        put_row(enc_i(12'h401, 5'd2, F3_SRA, 5'd16, OPC_IMM), "srai", 1'b1, 5'd16,
                32'hFFFF_FFFC, 32'h40);
        // Store x4 to byte address 20, then load it back
        put_row(enc_s(12'd8, 5'd4, 5'd1), "sw", 1'b0, 5'd0, 32'h0, 32'h44);
        put_row(enc_i(12'd20, 5'd0, F3_WORD, 5'd17, OPC_LOAD), "lw", 1'b1, 5'd17, 32'h13, 32'h48);
        put_row(enc_i(12'd5, 5'd0, F3_ADD, 5'd0, OPC_IMM), "addi_x0", 1'b1, 5'd0, 32'h5, 32'h4C);
        put_row(enc_r(F7_BASE, 5'd0, 5'd0, F3_ADD, 5'd18), "read_x0", 1'b1, 5'd18, 32'h0, 32'h50);
        put_row(enc_b(13'd8, 5'd1, 5'd1), "beq_taken", 1'b0, 5'd0, 32'h0, 32'h58);
        // Skipped rows write x31 and would show wb_valid if ever run
        put_row(enc_i(12'd1, 5'd0, F3_ADD, 5'd31, OPC_IMM), "skipped_a", 1'b0, 5'd0, 32'h0, 32'h58);
        put_row(enc_b(13'd8, 5'd2, 5'd1), "beq_untaken", 1'b0, 5'd0, 32'h0, 32'h5C);
        put_row(enc_i(12'h123, 5'd1, F3_ADD, 5'd5, OPC_BAD), "unknown_op", 1'b0, 5'd0, 32'h0, 32'h60);
        put_row(enc_j(21'd8, 5'd19), "jal", 1'b1, 5'd19, 32'h64, 32'h68);
        put_row(enc_i(12'd2, 5'd0, F3_ADD, 5'd31, OPC_IMM), "skipped_b", 1'b0, 5'd0, 32'h0, 32'h68);
        // Target 12 + 0x69 = 0x75, bit 0 dropped
        put_row(enc_i(12'h069, 5'd1, F3_ADD, 5'd20, OPC_JALR), "jalr", 1'b1, 5'd20, 32'h6C, 32'h74);
        put_row(enc_i(12'd3, 5'd0, F3_ADD, 5'd31, OPC_IMM), "skipped_c", 1'b0, 5'd0, 32'h0, 32'h70);
        put_row(enc_i(12'd4, 5'd0, F3_ADD, 5'd31, OPC_IMM), "skipped_d", 1'b0, 5'd0, 32'h0, 32'h74);
        put_row(enc_r(F7_BASE, 5'd19, 5'd20, F3_ADD, 5'd21), "link_sum", 1'b1, 5'd21, 32'hD0, 32'h78);
        put_row(enc_r(F7_BASE, 5'd0, 5'd31, F3_ADD, 5'd22), "x31_clean", 1'b1, 5'd22, 32'h0, 32'h7C);
    endtask

    task automatic check_word(input string sig, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", sig, got, exp);
            row_errors++;
        end
    endtask

    // Entered at a falling edge, leaves at the next one
    task automatic run_bubble();
        logic [31:0] held_pc;
        held_pc       = pc_o;
        instr_valid_i = 1'b0;
        // Junk on the bus, must be ignored
        instr_i       = $urandom;
        #(PERIOD / 2 - 1);
        check_word("wb_valid_o", 32'(wb_valid_o), 32'h0);
        @(negedge clk_i);
        check_word("pc_o", pc_o, held_pc);
    endtask

    task automatic run_instr(input int idx);
        instr_i       = prog_instr[idx];
        instr_valid_i = 1'b1;
        // Sample just before the rising edge
        #(PERIOD / 2 - 1);
        check_word("wb_valid_o", 32'(wb_valid_o), 32'(exp_valid[idx]));
        if (exp_valid[idx])
        begin
            check_word("wb_rd_o", 32'(wb_rd_o), 32'(exp_rd[idx]));
            check_word("wb_data_o", wb_data_o, exp_data[idx]);
        end
        @(negedge clk_i);
        check_word("pc_o", pc_o, exp_pc[idx]);
    endtask

    task automatic report_test(input string name);
        if (row_errors == 0)
        begin
            pass_count++;
            $display("PASS %s", name);
        end
        else
        begin
            fail_count++;
            $display("FAIL %s with %0d errors", name, row_errors);
        end
        row_errors = 0;
    endtask

    initial
    begin
        int idx;
        int n_bubbles;
        void'($urandom(70240));
        arst_n_i      = 1'b0;
        instr_i       = '0;
        instr_valid_i = 1'b0;
        row_count     = 0;
        row_errors    = 0;
        pass_count    = 0;
        fail_count    = 0;
        load_program();

        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;
        #(PERIOD / 2 - 1);
        check_word("pc_o", pc_o, 32'h0);
        check_word("wb_valid_o", 32'(wb_valid_o), 32'h0);
        report_test("reset_state");
        @(negedge clk_i);

        // Fetch follows the core's own PC until it runs off the table
        while (pc_o < 32'(4 * N_ROWS))
        begin
            idx       = int'(pc_o >> 2);
            n_bubbles = int'($urandom % 3);
            for (int b = 0; b < n_bubbles; b++)
            begin
                run_bubble();
            end
            run_instr(idx);
            report_test(prog_name[idx]);
        end
        instr_valid_i = 1'b0;

        $display("Summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0)
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Watchdog
    initial
    begin
        #(TIMEOUT_NS);
        $display("TIMEOUT: program did not reach its end within %0d ns", TIMEOUT_NS);
        $display("Test FAILED");
        $finish;
    end

endmodule

// File: verification/rv_core_asserts.sv
`timescale 1ns/10ps

module rv_core_asserts (
    input logic                    clk_i,
    input logic                    arst_n_i,
    input logic                    instr_valid_i,
    input logic [rv_pkg::XLEN-1:0] pc_i,
    input logic                    wb_valid_i,
    input logic                    mem_write_i
);

    // Bubble leaves data memory alone
    bubble_quiet: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        !instr_valid_i |-> !mem_write_i
    ) else $error("memory write during a bubble");

    // Fetch address always on a word boundary
    pc_aligned: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        pc_i[1:0] == 2'b00
    ) else $error("pc_o not word aligned");

    // No issue, no PC update
    pc_hold: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        !instr_valid_i |=> $stable(pc_i)
    ) else $error("pc_o moved after a bubble");

    // Write-back only for an issued instruction
    wb_needs_valid: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        wb_valid_i |-> instr_valid_i
    ) else $error("wb_valid_o high without instr_valid_i");

endmodule

// Attached to every core instance
bind rv_core rv_core_asserts rv_core_asserts_i (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .instr_valid_i (instr_valid_i),
    .pc_i          (pc_o),
    .wb_valid_i    (wb_valid_o),
    .mem_write_i   (mem_write)
);

// File: logic/rv_core.sv
`timescale 1ns/10ps

module rv_core (
    input  logic                          clk_i,
    input  logic                          arst_n_i,
    input  logic [rv_pkg::XLEN-1:0]       instr_i,
    input  logic                          instr_valid_i,
    output logic [rv_pkg::XLEN-1:0]       pc_o,
    output logic                          wb_valid_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [rv_pkg::XLEN-1:0]       wb_data_o
);

    import rv_pkg::*;

    // Decode outputs
    logic                  issue;
    logic                  jalr;
    logic                  jal;
    logic                  branch;
    logic                  mem_read;
    logic                  mem_to_reg;
    logic                  mem_write;
    logic [1:0]            alu_op;
    logic                  alu_src;
    logic                  reg_write;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       imm;
    logic [REG_ADDR_W-1:0] rd;
    logic [2:0]            funct3;
    logic                  funct7_bit5;

    // Execute and result outputs
    logic [XLEN-1:0]       alu_result;
    logic [XLEN-1:0]       pc_plus4;
    logic [XLEN-1:0]       wb_data;

    decode_stage decode_stage_i (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .wb_we_i       (reg_write),
        .wb_rd_i       (rd),
        .wb_data_i     (wb_data),
        .issue_o       (issue),
        .jalr_o        (jalr),
        .jal_o         (jal),
        .branch_o      (branch),
        .mem_read_o    (mem_read),
        .mem_to_reg_o  (mem_to_reg),
        .mem_write_o   (mem_write),
        .alu_op_o      (alu_op),
        .alu_src_o     (alu_src),
        .reg_write_o   (reg_write),
        .rs1_data_o    (rs1_data),
        .rs2_data_o    (rs2_data),
        .imm_o         (imm),
        .rd_o          (rd),
        .funct3_o      (funct3),
        .funct7_bit5_o (funct7_bit5)
    );

    execute_stage execute_stage_i (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .issue_i       (issue),
        .alu_op_i      (alu_op),
        .alu_src_i     (alu_src),
        .branch_i      (branch),
        .jal_i         (jal),
        .jalr_i        (jalr),
        .funct3_i      (funct3),
        .funct7_bit5_i (funct7_bit5),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .imm_i         (imm),
        .alu_result_o  (alu_result),
        .pc_plus4_o    (pc_plus4),
        .pc_o          (pc_o)
    );

    // Link for either jump
    result_stage result_stage_i (
        .clk_i         (clk_i),
        .mem_read_i    (mem_read),
        .mem_write_i   (mem_write),
        .mem_to_reg_i  (mem_to_reg),
        .jump_link_i   (jal | jalr),
        .alu_result_i  (alu_result),
        .store_data_i  (rs2_data),
        .pc_plus4_i    (pc_plus4),
        .wb_data_o     (wb_data)
    );

    // Write-back trace
    assign wb_valid_o = reg_write;
    assign wb_rd_o    = rd;
    assign wb_data_o  = wb_data;

endmodule

// File: logic/result_stage.sv
`timescale 1ns/10ps

module result_stage (
    input  logic                    clk_i,
    input  logic                    mem_read_i,
    input  logic                    mem_write_i,
    input  logic                    mem_to_reg_i,
    input  logic                    jump_link_i,
    input  logic [rv_pkg::XLEN-1:0] alu_result_i,
    input  logic [rv_pkg::XLEN-1:0] store_data_i,
    input  logic [rv_pkg::XLEN-1:0] pc_plus4_i,
    output logic [rv_pkg::XLEN-1:0] wb_data_o
);

    import rv_pkg::*;

    logic [XLEN-1:0]        dmem [DMEM_WORDS];
    logic [DMEM_ADDR_W-1:0] word_addr;
    logic [XLEN-1:0]        load_data;

    // Word index from byte address
    assign word_addr = alu_result_i[DMEM_ADDR_W+1:2];

    // Synchronous store
    always_ff @(posedge clk_i)
    begin
        if (mem_write_i)
        begin
            dmem[word_addr] <= store_data_i;
        end
    end

    // Asynchronous load, zero when not a load
    assign load_data = mem_read_i ? dmem[word_addr] : '0;

    // Write-back select
    always_comb
    begin
        if (mem_to_reg_i)
            wb_data_o = load_data;
        else if (jump_link_i)
            // Link address for jal and jalr
            wb_data_o = pc_plus4_i;
        else
            wb_data_o = alu_result_i;
    end

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/10ps

module execute_stage (
    input  logic                    clk_i,
    input  logic                    arst_n_i,
    input  logic                    issue_i,
    input  logic [1:0]              alu_op_i,
    input  logic                    alu_src_i,
    input  logic                    branch_i,
    input  logic                    jal_i,
    input  logic                    jalr_i,
    input  logic [2:0]              funct3_i,
    input  logic                    funct7_bit5_i,
    input  logic [rv_pkg::XLEN-1:0] rs1_data_i,
    input  logic [rv_pkg::XLEN-1:0] rs2_data_i,
    input  logic [rv_pkg::XLEN-1:0] imm_i,
    output logic [rv_pkg::XLEN-1:0] alu_result_o,
    output logic [rv_pkg::XLEN-1:0] pc_plus4_o,
    output logic [rv_pkg::XLEN-1:0] pc_o
);

    import rv_pkg::*;

    alu_fn_e         alu_fn;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_next;
    logic [XLEN-1:0] jalr_target;
    logic            beq_taken;

    // ALU control
    always_comb
    begin
        alu_fn = ALU_ADD;
        case (alu_op_i)
            ALUOP_R, ALUOP_I:
            begin
                case (funct3_i)
                    // sub only exists in R form
                    F3_ADD_SUB: alu_fn = (alu_op_i == ALUOP_R && funct7_bit5_i) ? ALU_SUB
                                                                                 : ALU_ADD;
                    F3_SLL:     alu_fn = ALU_SLL;
                    F3_SLT:     alu_fn = ALU_SLT;
                    F3_XOR:     alu_fn = ALU_XOR;
                    F3_SR:      alu_fn = ALU_SRA;
                    F3_OR:      alu_fn = ALU_OR;
                    F3_AND:     alu_fn = ALU_AND;
                    default:    alu_fn = ALU_ADD;
                endcase
            end
            // Address generation for lw, sw and friends
            ALUOP_ADD: alu_fn = ALU_ADD;
            default:   alu_fn = ALU_ADD;
        endcase
    end

    assign op_b = alu_src_i ? imm_i : rs2_data_i;

    // ALU, shift amount from low 5 bits
    always_comb
    begin
        case (alu_fn)
            ALU_ADD: alu_result_o = rs1_data_i + op_b;
            ALU_SUB: alu_result_o = rs1_data_i - op_b;
            ALU_AND: alu_result_o = rs1_data_i & op_b;
            ALU_OR:  alu_result_o = rs1_data_i | op_b;
            ALU_XOR: alu_result_o = rs1_data_i ^ op_b;
            ALU_SLL: alu_result_o = rs1_data_i << op_b[4:0];
            ALU_SLT: alu_result_o = {{(XLEN-1){1'b0}}, $signed(rs1_data_i) < $signed(op_b)};
            ALU_SRA: alu_result_o = $unsigned($signed(rs1_data_i) >>> op_b[4:0]);
            default: alu_result_o = '0;
        endcase
    end

    // Next PC
    assign pc_plus4_o  = pc_q + XLEN'(4);
    assign beq_taken   = branch_i && (rs1_data_i == rs2_data_i);
    assign jalr_target = (rs1_data_i + imm_i) & ~XLEN'(1);

    always_comb
    begin
        if (jalr_i)
            pc_next = jalr_target;
        else if (beq_taken || jal_i)
            pc_next = pc_q + imm_i;
        else
            pc_next = pc_plus4_o;
    end

    // PC holds through bubbles
    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
            pc_q <= '0;
        else if (issue_i)
            pc_q <= pc_next;
    end

    assign pc_o = pc_q;

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
    input  logic                          clk_i,
    input  logic                          arst_n_i,
    input  logic [rv_pkg::XLEN-1:0]       instr_i,
    input  logic                          instr_valid_i,
    input  logic                          wb_we_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] wb_rd_i,
    input  logic [rv_pkg::XLEN-1:0]       wb_data_i,
    output logic                          issue_o,
    output logic                          jalr_o,
    output logic                          jal_o,
    output logic                          branch_o,
    output logic                          mem_read_o,
    output logic                          mem_to_reg_o,
    output logic                          mem_write_o,
    output logic [1:0]                    alu_op_o,
    output logic                          alu_src_o,
    output logic                          reg_write_o,
    output logic [rv_pkg::XLEN-1:0]       rs1_data_o,
    output logic [rv_pkg::XLEN-1:0]       rs2_data_o,
    output logic [rv_pkg::XLEN-1:0]       imm_o,
    output logic [rv_pkg::REG_ADDR_W-1:0] rd_o,
    output logic [2:0]                    funct3_o,
    output logic                          funct7_bit5_o
);

    import rv_pkg::*;

    instr_u instr;

    assign instr = instr_i;

    // Only place validity is looked at, a bubble is a no-op
    assign issue_o = instr_valid_i;

    assign rd_o          = instr.r_fmt.rd;
    assign funct3_o      = instr.r_fmt.funct3;
    assign funct7_bit5_o = instr.r_fmt.funct7[F7_ALT_BIT];

    control_unit control_unit_i (
        .opcode_i     (instr.r_fmt.opcode),
        .noop_i       (~issue_o),
        .jalr_o       (jalr_o),
        .jal_o        (jal_o),
        .branch_o     (branch_o),
        .mem_read_o   (mem_read_o),
        .mem_to_reg_o (mem_to_reg_o),
        .alu_op_o     (alu_op_o),
        .mem_write_o  (mem_write_o),
        .alu_src_o    (alu_src_o),
        .reg_write_o  (reg_write_o)
    );

    reg_file reg_file_i (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .rs1_addr_i (instr.r_fmt.rs1),
        .rs2_addr_i (instr.r_fmt.rs2),
        .rd_addr_i  (wb_rd_i),
        .rd_we_i    (wb_we_i),
        .rd_data_i  (wb_data_i),
        .rs1_data_o (rs1_data_o),
        .rs2_data_o (rs2_data_o)
    );

    // Immediate format picked by opcode, always sign-extended
    always_comb
    begin
        case (instr.r_fmt.opcode)
            OP_I, OP_LOAD, OP_JALR:
                imm_o = {{(XLEN-12){instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
            OP_STORE:
                imm_o = {{(XLEN-12){instr.s_fmt.imm_11_5[6]}},
                         instr.s_fmt.imm_11_5, instr.s_fmt.imm_4_0};
            OP_BRANCH:
                imm_o = {{(XLEN-12){instr.b_fmt.imm_12}}, instr.b_fmt.imm_11,
                         instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
            OP_JAL:
                imm_o = {{(XLEN-20){instr.j_fmt.imm_20}}, instr.j_fmt.imm_19_12,
                         instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};
            default:
                imm_o = '0;
        endcase
    end

endmodule

// File: logic/reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic                          clk_i,
    input  logic                          arst_n_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rd_addr_i,
    input  logic                          rd_we_i,
    input  logic [rv_pkg::XLEN-1:0]       rd_data_i,
    output logic [rv_pkg::XLEN-1:0]       rs1_data_o,
    output logic [rv_pkg::XLEN-1:0]       rs2_data_o
);

    import rv_pkg::*;

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    // Write port, x0 never written
    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            for (int i = 0; i < 2**REG_ADDR_W; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (rd_we_i && (rd_addr_i != '0))
        begin
            regs[rd_addr_i] <= rd_data_i;
        end
    end

    // Combinational reads, x0 hardwired
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// File: logic/control_unit.sv
`timescale 1ns/10ps

module control_unit (
    input  logic [6:0] opcode_i,
    input  logic       noop_i,
    output logic       jalr_o,
    output logic       jal_o,
    output logic       branch_o,
    output logic       mem_read_o,
    output logic       mem_to_reg_o,
    output logic [1:0] alu_op_o,
    output logic       mem_write_o,
    output logic       alu_src_o,
    output logic       reg_write_o
);

    import rv_pkg::*;

    always_comb
    begin
        // Everything off unless a known opcode says otherwise
        jalr_o       = 1'b0;
        jal_o        = 1'b0;
        branch_o     = 1'b0;
        mem_read_o   = 1'b0;
        mem_to_reg_o = 1'b0;
        alu_op_o     = ALUOP_ADD;
        mem_write_o  = 1'b0;
        alu_src_o    = 1'b0;
        reg_write_o  = 1'b0;

        if (!noop_i)
        begin
            // R-type forced to 01, the rest take opcode[4:3]
            alu_op_o = (opcode_i == OP_R) ? ALUOP_R : opcode_i[4:3];

            case (opcode_i)
                OP_R:
                begin
                    reg_write_o = 1'b1;
                end
                OP_I:
                begin
                    alu_src_o   = 1'b1;
                    reg_write_o = 1'b1;
                end
                OP_STORE:
                begin
                    mem_write_o = 1'b1;
                    alu_src_o   = 1'b1;
                end
                OP_LOAD:
                begin
                    mem_read_o   = 1'b1;
                    mem_to_reg_o = 1'b1;
                    alu_src_o    = 1'b1;
                    reg_write_o  = 1'b1;
                end
                OP_BRANCH:
                begin
                    branch_o = 1'b1;
                end
                OP_JAL:
                begin
                    jal_o       = 1'b1;
                    reg_write_o = 1'b1;
                end
                OP_JALR:
                begin
                    jalr_o      = 1'b1;
                    reg_write_o = 1'b1;
                end
                default:
                begin
                    // Unknown opcode behaves as a no-op
                    alu_op_o = ALUOP_ADD;
                end
            endcase
        end
    end

endmodule

// File: logic/rv_pkg.sv
package rv_pkg;

    // Datapath widths
    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int DMEM_WORDS  = 64;
    localparam int DMEM_ADDR_W = $clog2(DMEM_WORDS);

    // Major opcodes
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    // alu_op classes from the control unit
    localparam logic [1:0] ALUOP_ADD = 2'b00;
    localparam logic [1:0] ALUOP_R   = 2'b01;
    localparam logic [1:0] ALUOP_I   = 2'b10;

    // funct3 codes, shared by R and I forms
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 bit picking sub over add
    localparam int F7_ALT_BIT = 5;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SLT,
        ALU_SRA
    } alu_fn_e;

    // Instruction formats, MSB first
    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm_11_0;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_11_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_4_0;
        logic [6:0]            opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        logic [6:0]            opcode;
    } b_fmt_t;

    typedef struct packed {
        logic                  imm_20;
        logic [9:0]            imm_10_1;
        logic                  imm_11;
        logic [7:0]            imm_19_12;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } j_fmt_t;

    // One word, five views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
    } instr_u;

endpackage
